// ==== filelist.f ====
+incdir+include
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/instr_decoder.sv
hdl/dispatch_unit.sv
hdl/int_alu.sv
hdl/iter_multiplier.sv
hdl/result_bus.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
sim/ooo_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the ooo_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module ooo_core_tb -o ooo_core_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/ooo_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== sim/ooo_core_tb.sv ====
`timescale 1ns/1ps

`include "core_consts.svh"

module ooo_core_tb;

    import isa_pkg::*;
    import core_pkg::*;

    // one program row, fields kept beside the encoded word
    typedef struct packed {
        opcode_e                  op;
        logic [`REG_ADDR_LEN-1:0] rd;
        logic [`REG_ADDR_LEN-1:0] rs1;
        logic [`REG_ADDR_LEN-1:0] rs2;
        logic [`XLEN-1:0]         imm;
        logic [31:0]              word;
    } row_t;

    logic        clock = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        stall;
    commit_t     commit_out;

    row_t        rows [$];
    commit_t     exp_q [$];
    commit_t     exp_commit;
    logic [`XLEN-1:0] gold_regs [`REG_NUM];
    logic [31:0] lcg_state = 32'd34187;
    int          errors  = 0;
    int          checked = 0;

    ooo_core DUT (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .commit      (commit_out)
    );

    // 100 ns period
    always #50 clock = ~clock;

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // classic lcg, upper bits are the better ones
    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'h0, lcg_state[31:16]};
    endfunction

    function logic [31:0] encode_instr(opcode_e op, logic [4:0] rd, logic [4:0] rs1,
                                       logic [4:0] rs2, logic [31:0] imm);
        case (op)
            OP_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            OP_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            OP_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            OP_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            OP_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            OP_SLT:  return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            OP_MUL:  return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
            OP_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            default: return 32'hffff_ffff;
        endcase
    endfunction

    task automatic add_row(opcode_e op, logic [4:0] rd, logic [4:0] rs1,
                           logic [4:0] rs2, logic [31:0] imm);
        row_t r;
        r.op   = op;
        r.rd   = rd;
        r.rs1  = rs1;
        r.rs2  = (op == OP_ADDI) ? 5'd0 : rs2;
        r.imm  = imm;
        r.word = encode_instr(op, rd, rs1, rs2, imm);
        rows.push_back(r);
    endtask

    // raw word, expected to be rejected by the decoder
    task automatic add_illegal(logic [31:0] word);
        row_t r;
        r      = '0;
        r.op   = OP_ILLEGAL;
        r.word = word;
        rows.push_back(r);
    endtask

    task automatic add_random_addi();
        logic [31:0] r;
        r = lcg_next();
        add_row(OP_ADDI, 5'(lcg_next()), 5'(lcg_next()), 5'd0, {{20{r[11]}}, r[11:0]});
    endtask

    //////////////////////////////
    // golden model
    //////////////////////////////

    function logic [31:0] gold_result(opcode_e op, logic [31:0] a, logic [31:0] b);
        logic [31:0] lt;
        lt = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        case (op)
            OP_ADD, OP_ADDI: return a + b;
            OP_SUB:          return a - b;
            OP_AND:          return a & b;
            OP_OR:           return a | b;
            OP_XOR:          return a ^ b;
            OP_SLT:          return lt;
            // low half of the product
            OP_MUL:          return a * b;
            default:         return 32'd0;
        endcase
    endfunction

    // program order walk, one expected commit per legal row
    task automatic build_expected();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        commit_t     c;
        for (int i = 0; i < `REG_NUM; i++) begin
            gold_regs[i] = '0;
        end
        foreach (rows[i]) begin
            if (rows[i].op != OP_ILLEGAL) begin
                a = gold_regs[rows[i].rs1];
                b = (rows[i].op == OP_ADDI) ? rows[i].imm : gold_regs[rows[i].rs2];
                r = gold_result(rows[i].op, a, b);
                if (rows[i].rd != 0) begin
                    gold_regs[rows[i].rd] = r;
                end
                c.valid = 1'b1;
                c.rd    = rows[i].rd;
                c.data  = (rows[i].rd == 0) ? '0 : r;
                exp_q.push_back(c);
            end
        end
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_commit(commit_t got, commit_t exp);
        checked++;
        if (got.rd !== exp.rd || got.data !== exp.data) begin
            errors++;
            $display("ERROR %0t: commit rd %0d data %08h, expected rd %0d data %08h",
                     $realtime, got.rd, got.data, exp.rd, exp.data);
        end
    endtask

    task automatic check_idle(logic stall_lvl, commit_t c);
        if (stall_lvl !== 1'b0 || c.valid !== 1'b0) begin
            errors++;
            $display("ERROR %0t: core not idle, stall %b commit valid %b",
                     $realtime, stall_lvl, c.valid);
        end
    endtask

    // commits sampled mid cycle, away from the edges
    always @(negedge clock) begin
        if (reset === 1'b0 && commit_out.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR %0t: unexpected commit rd %0d data %08h",
                         $realtime, commit_out.rd, commit_out.data);
            end else begin
                exp_commit = exp_q.pop_front();
                check_commit(commit_out, exp_commit);
            end
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        bit accepted;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;

        // basic ops, negative imm, back to back deps
        add_row(OP_ADDI, 5'd1, 5'd0, 5'd0, 32'd5);
        add_row(OP_ADDI, 5'd2, 5'd0, 5'd0, -32'sd3);
        add_row(OP_ADD,  5'd3, 5'd1, 5'd2, 32'd0);
        add_row(OP_SUB,  5'd4, 5'd2, 5'd1, 32'd0);
        add_row(OP_AND,  5'd5, 5'd1, 5'd2, 32'd0);
        add_row(OP_OR,   5'd6, 5'd1, 5'd2, 32'd0);
        add_row(OP_XOR,  5'd7, 5'd1, 5'd2, 32'd0);
        add_row(OP_SLT,  5'd8, 5'd2, 5'd1, 32'd0);
        add_row(OP_SLT,  5'd9, 5'd1, 5'd2, 32'd0);
        // mul, then a consumer that has to wait
        add_row(OP_MUL,  5'd10, 5'd1, 5'd2, 32'd0);
        add_row(OP_ADD,  5'd11, 5'd10, 5'd1, 32'd0);
        // mul followed by enough alu ops to fill the rob
        add_row(OP_MUL,  5'd12, 5'd3, 5'd4, 32'd0);
        for (int k = 0; k < 9; k++) begin
            add_row(OP_ADDI, 5'(13 + k), 5'd1, 5'd0, 32'(k * 7 - 20));
        end
        add_illegal(32'hffff_ffff);
        add_illegal(32'h0000_0073);
        // mulh encoding, outside the subset
        add_illegal({7'b0000001, 5'd2, 5'd1, 3'b001, 5'd5, 7'b0110011});
        // x0 as target, then as source
        add_row(OP_ADDI, 5'd0, 5'd1, 5'd0, 32'd9);
        add_row(OP_ADD,  5'd22, 5'd0, 5'd1, 32'd0);
        // two writers to one register in flight
        add_row(OP_ADDI, 5'd1, 5'd1, 5'd0, 32'd1);
        add_row(OP_ADDI, 5'd1, 5'd1, 5'd0, 32'd1);
        add_row(OP_MUL,  5'd23, 5'd1, 5'd12, 32'd0);
        for (int k = 0; k < 6; k++) begin
            add_random_addi();
        end
        add_row(OP_MUL, 5'(lcg_next()), 5'(lcg_next()), 5'(lcg_next()), 32'd0);
        add_row(OP_SLT, 5'(lcg_next()), 5'(lcg_next()), 5'(lcg_next()), 32'd0);
        add_row(OP_SUB, 5'(lcg_next()), 5'(lcg_next()), 5'(lcg_next()), 32'd0);
        build_expected();

        repeat (16) @(posedge clock);
        #10;
        reset = 1'b0;

        // nothing may move before the first instruction
        repeat (4) begin
            @(negedge clock);
            check_idle(stall, commit_out);
        end
        @(posedge clock);
        #10;

        // each row held until a cycle without stall
        foreach (rows[i]) begin
            instr_valid = 1'b1;
            instr       = rows[i].word;
            accepted    = 1'b0;
            while (!accepted) begin
                @(negedge clock);
                accepted = !stall;
                @(posedge clock);
                #10;
            end
        end
        instr_valid = 1'b0;
        instr       = '0;

        // drain, then a margin for stray commits
        while (exp_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (20) @(posedge clock);

        $display("commits checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    //////////////////////////////
    // watchdog
    //////////////////////////////

    initial begin
        int limit;
        @(negedge reset);
        limit = rows.size() * (`MUL_CYCLES + `ROB_DEPTH + 4) + 100;
        repeat (limit) @(posedge clock);
        $display("timeout after %0d cycles, %0d expected commits never arrived",
                 limit, exp_q.size());
        $display("commits checked: %0d, errors: %0d", checked, errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== hdl/ooo_core.sv ====
`timescale 1ns/1ps

`include "core_consts.svh"

module ooo_core (
    input  logic               clock,
    input  logic               reset,
    input  logic               instr_valid,
    input  logic [31:0]        instr,
    output logic               stall,
    output core_pkg::commit_t  commit
);

    import isa_pkg::*;
    import core_pkg::*;

    decoded_t                 decoded;
    logic                     alloc;
    logic [`REG_ADDR_LEN-1:0] alloc_rd;
    rob_tag_t                 alloc_tag;
    rob_tag_t                 commit_tag;
    logic                     rob_full;
    rob_view_t                rob_view;

    // execute side
    exec_op_t                 alu_op;
    exec_op_t                 mul_op;
    result_t                  alu_result;
    result_t                  mul_result;
    logic                     alu_busy;
    logic                     mul_busy;
    logic                     alu_grant;
    logic                     mul_grant;
    result_t                  bus;

    //////////////////////////////
    // decode and dispatch
    //////////////////////////////

    instr_decoder decoder_0 (
        .instr   (instr),
        .decoded (decoded)
    );

    dispatch_unit dispatch_0 (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .decoded     (decoded),
        .alloc_tag   (alloc_tag),
        .rob_full    (rob_full),
        .rob_view    (rob_view),
        .commit      (commit),
        .commit_tag  (commit_tag),
        .alu_busy    (alu_busy),
        .mul_busy    (mul_busy),
        .stall       (stall),
        .alloc       (alloc),
        .alloc_rd    (alloc_rd),
        .alu_op      (alu_op),
        .mul_op      (mul_op)
    );

    //////////////////////////////
    // execute
    //////////////////////////////

    int_alu alu_0 (
        .clock  (clock),
        .reset  (reset),
        .op     (alu_op),
        .grant  (alu_grant),
        .result (alu_result),
        .busy   (alu_busy)
    );

    iter_multiplier mul_0 (
        .clock  (clock),
        .reset  (reset),
        .op     (mul_op),
        .grant  (mul_grant),
        .result (mul_result),
        .busy   (mul_busy)
    );

    //////////////////////////////
    // complete and retire
    //////////////////////////////

    result_bus cdb_0 (
        .alu_result (alu_result),
        .mul_result (mul_result),
        .bus        (bus),
        .alu_grant  (alu_grant),
        .mul_grant  (mul_grant)
    );

    reorder_buffer rob_0 (
        .clock      (clock),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_rd   (alloc_rd),
        .bus        (bus),
        .alloc_tag  (alloc_tag),
        .rob_full   (rob_full),
        .rob_view   (rob_view),
        .commit     (commit),
        .commit_tag (commit_tag)
    );

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps

`include "core_consts.svh"

module reorder_buffer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      alloc,
    input  logic [`REG_ADDR_LEN-1:0]  alloc_rd,
    input  core_pkg::result_t         bus,
    output core_pkg::rob_tag_t        alloc_tag,
    output logic                      rob_full,
    output core_pkg::rob_view_t       rob_view,
    output core_pkg::commit_t         commit,
    output core_pkg::rob_tag_t        commit_tag
);

    import core_pkg::*;

    // entry storage
    logic [`REG_ADDR_LEN-1:0] rd_q   [`ROB_DEPTH];
    logic [`XLEN-1:0]         data_q [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]    done_q;

    // circular pointers
    rob_tag_t                 head;
    rob_tag_t                 tail;
    logic [`ROB_TAG_LEN:0]    count;
    logic                     retire;

    //////////////////////////////
    // allocate side
    //////////////////////////////

    assign alloc_tag = tail;
    assign rob_full  = (count == `ROB_DEPTH);

    //////////////////////////////
    // commit side
    //////////////////////////////

    // head retires once its done bit is registered
    assign retire     = (count != '0) && done_q[head];
    assign commit_tag = head;

    always_comb begin
        commit.valid = retire;
        commit.rd    = rd_q[head];
        // x0 reports zero
        commit.data  = (rd_q[head] == '0) ? '0 : data_q[head];
    end

    // forwarding view for dispatch
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            rob_view[i].done = done_q[i];
            rob_view[i].data = data_q[i];
        end
    end

    //////////////////////////////
    // state update
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            // completion from the result bus
            if (bus.valid) begin
                done_q[bus.tag] <= 1'b1;
                data_q[bus.tag] <= bus.data;
            end
            // fresh slot, not done yet
            if (alloc) begin
                rd_q[tail]   <= alloc_rd;
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            // net occupancy
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/result_bus.sv ====
`timescale 1ns/1ps

`include "core_consts.svh"

module result_bus (
    input  core_pkg::result_t  alu_result,
    input  core_pkg::result_t  mul_result,
    output core_pkg::result_t  bus,
    output logic               alu_grant,
    output logic               mul_grant
);

    import core_pkg::*;

    unit_e sel;

    // fixed priority, multiplier first
    // ALU holds its result until picked
    always_comb begin
        sel       = mul_result.valid ? UNIT_MUL : UNIT_ALU;
        mul_grant = mul_result.valid;
        alu_grant = alu_result.valid && (sel == UNIT_ALU);
        case (sel)
            UNIT_MUL: bus = mul_result;
            default:  bus = alu_result;
        endcase
    end

endmodule

// ==== hdl/iter_multiplier.sv ====
`timescale 1ns/1ps

`include "core_consts.svh"

module iter_multiplier (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::exec_op_t  op,
    input  logic                grant,
    output core_pkg::result_t   result,
    output logic                busy
);

    import core_pkg::*;

    localparam int STEP_W = $clog2(`MUL_CYCLES);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_e;

    mul_state_e        state;
    logic [STEP_W-1:0] step;
    logic [`XLEN-1:0]  mcand;
    logic [`XLEN-1:0]  mplier;
    logic [`XLEN-1:0]  acc;
    logic [`XLEN-1:0]  partial;
    rob_tag_t          tag;

    // low slice of mplier times shifted mcand
    always_comb begin
        partial = '0;
        for (int i = 0; i < `MUL_BITS_PER_CYCLE; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= MUL_IDLE;
        end else begin
            case (state)
                MUL_RUN: begin
                    acc    <= acc + partial;
                    mcand  <= mcand << `MUL_BITS_PER_CYCLE;
                    mplier <= mplier >> `MUL_BITS_PER_CYCLE;
                    step   <= step + 1'b1;
                    if (step == STEP_W'(`MUL_CYCLES - 1)) begin
                        state <= MUL_DONE;
                    end
                end
                MUL_DONE: begin
                    if (grant) begin
                        state <= MUL_IDLE;
                    end
                end
                default: state <= MUL_IDLE;
            endcase
            // start, also right on the grant edge
            if (op.valid) begin
                state  <= MUL_RUN;
                step   <= '0;
                acc    <= '0;
                mcand  <= op.a;
                mplier <= op.b;
                tag    <= op.tag;
            end
        end
    end

    assign result.valid = (state == MUL_DONE);
    assign result.tag   = tag;
    assign result.data  = acc;
    // busy from start until granted
    assign busy = (state != MUL_IDLE) && !(state == MUL_DONE && grant);

endmodule

// ==== hdl/int_alu.sv ====
`timescale 1ns/1ps

`include "core_consts.svh"

module int_alu (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::exec_op_t  op,
    input  logic                grant,
    output core_pkg::result_t   result,
    output logic                busy
);

    import isa_pkg::*;
    import core_pkg::*;

    logic [`XLEN-1:0] alu_out;

    always_comb begin
        case (op.op)
            OP_ADD, OP_ADDI: alu_out = op.a + op.b;
            OP_SUB:          alu_out = op.a - op.b;
            OP_AND:          alu_out = op.a & op.b;
            OP_OR:           alu_out = op.a | op.b;
            OP_XOR:          alu_out = op.a ^ op.b;
            // signed compare
            OP_SLT:          alu_out = {{(`XLEN-1){1'b0}}, $signed(op.a) < $signed(op.b)};
            default:         alu_out = '0;
        endcase
    end

    // holding register, waits for the result bus
    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            if (grant) begin
                result.valid <= 1'b0;
            end
            // refill on the grant edge is allowed
            if (op.valid) begin
                result.valid <= 1'b1;
                result.tag   <= op.tag;
                result.data  <= alu_out;
            end
        end
    end

    assign busy = result.valid && !grant;

endmodule

// ==== hdl/dispatch_unit.sv ====
`timescale 1ns/1ps

`include "core_consts.svh"

module dispatch_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  isa_pkg::decoded_t         decoded,
    input  core_pkg::rob_tag_t        alloc_tag,
    input  logic                      rob_full,
    input  core_pkg::rob_view_t       rob_view,
    input  core_pkg::commit_t         commit,
    input  core_pkg::rob_tag_t        commit_tag,
    input  logic                      alu_busy,
    input  logic                      mul_busy,
    output logic                      stall,
    output logic                      alloc,
    output logic [`REG_ADDR_LEN-1:0]  alloc_rd,
    output core_pkg::exec_op_t        alu_op,
    output core_pkg::exec_op_t        mul_op
);

    import isa_pkg::*;
    import core_pkg::*;

    // architectural state
    logic [`XLEN-1:0]   regs    [`REG_NUM];
    logic [`REG_NUM-1:0] pending;
    // youngest in-flight writer per register
    rob_tag_t           writer  [`REG_NUM];

    logic               src1_ready;
    logic               src2_ready;
    logic [`XLEN-1:0]   src1_val;
    logic [`XLEN-1:0]   src2_val;
    logic [`XLEN-1:0]   opnd_b;
    unit_e              target;
    logic               target_busy;
    logic               issue;

    //////////////////////////////
    // operand select
    //////////////////////////////

    always_comb begin
        // pending source reads the rob entry, once done
        src1_ready = !pending[decoded.rs1] || rob_view[writer[decoded.rs1]].done;
        src2_ready = !pending[decoded.rs2] || rob_view[writer[decoded.rs2]].done;
        src1_val   = pending[decoded.rs1] ? rob_view[writer[decoded.rs1]].data
                                          : regs[decoded.rs1];
        src2_val   = pending[decoded.rs2] ? rob_view[writer[decoded.rs2]].data
                                          : regs[decoded.rs2];
        opnd_b     = decoded.use_imm ? decoded.imm : src2_val;
    end

    //////////////////////////////
    // stall and issue
    //////////////////////////////

    assign target      = (decoded.op == OP_MUL) ? UNIT_MUL : UNIT_ALU;
    assign target_busy = (target == UNIT_MUL) ? mul_busy : alu_busy;

    // illegal words pass through, never stall
    assign stall = instr_valid && decoded.valid
                   && (rob_full || !src1_ready || !src2_ready || target_busy);
    assign issue    = instr_valid && decoded.valid && !stall;
    assign alloc    = issue;
    assign alloc_rd = decoded.rd;

    always_comb begin
        alu_op.valid = issue && (target == UNIT_ALU);
        alu_op.op    = decoded.op;
        alu_op.a     = src1_val;
        alu_op.b     = opnd_b;
        alu_op.tag   = alloc_tag;
        // same payload, own strobe
        mul_op       = alu_op;
        mul_op.valid = issue && (target == UNIT_MUL);
    end

    //////////////////////////////
    // regfile and scoreboard
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= '0;
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // retire first, x0 stays zero
            if (commit.valid && commit.rd != '0) begin
                regs[commit.rd] <= commit.data;
                // older writer retiring leaves a younger one pending
                if (writer[commit.rd] == commit_tag) begin
                    pending[commit.rd] <= 1'b0;
                end
            end
            // new writer wins over a same-edge retire
            if (alloc && alloc_rd != '0) begin
                pending[alloc_rd] <= 1'b1;
                writer[alloc_rd]  <= alloc_tag;
            end
        end
    end

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps

`include "core_consts.svh"

module instr_decoder (
    input  logic [31:0]        instr,
    output isa_pkg::decoded_t  decoded
);

    import isa_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];

    always_comb begin
        // register fields sit in fixed places
        decoded.rd      = instr[11:7];
        decoded.rs1     = instr[19:15];
        decoded.rs2     = instr[24:20];
        decoded.use_imm = 1'b0;
        // I-type immediate, sign extended
        decoded.imm     = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        decoded.op      = OP_ILLEGAL;
        case (opcode)
            // OP, R-type
            7'b0110011: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  decoded.op = OP_ADD;
                        3'b010:  decoded.op = OP_SLT;
                        3'b100:  decoded.op = OP_XOR;
                        3'b110:  decoded.op = OP_OR;
                        3'b111:  decoded.op = OP_AND;
                        default: decoded.op = OP_ILLEGAL;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    decoded.op = OP_SUB;
                end else if (funct7 == 7'b0000001 && funct3 == 3'b000) begin
                    decoded.op = OP_MUL;
                end
            end
            // OP-IMM, only addi
            7'b0010011: begin
                if (funct3 == 3'b000) begin
                    decoded.op      = OP_ADDI;
                    decoded.use_imm = 1'b1;
                    // rs2 bits are imm here, x0 never pends
                    decoded.rs2     = '0;
                end
            end
            default: decoded.op = OP_ILLEGAL;
        endcase
        decoded.valid = (decoded.op != OP_ILLEGAL);
    end

endmodule

// ==== hdl/core_pkg.sv ====
package core_pkg;

`include "core_consts.svh"

    import isa_pkg::*;

    // reorder buffer slot index
    typedef logic [`ROB_TAG_LEN-1:0] rob_tag_t;

    // execute unit select
    typedef enum logic {
        UNIT_ALU,
        UNIT_MUL
    } unit_e;

    // one issued op, dispatch to unit
    typedef struct packed {
        logic             valid;
        opcode_e          op;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        rob_tag_t         tag;
    } exec_op_t;

    // unit output and result bus output
    typedef struct packed {
        logic             valid;
        rob_tag_t         tag;
        logic [`XLEN-1:0] data;
    } result_t;

    // in-order retire, also the regfile write
    typedef struct packed {
        logic                     valid;
        logic [`REG_ADDR_LEN-1:0] rd;
        logic [`XLEN-1:0]         data;
    } commit_t;

    // per-entry forwarding view
    typedef struct packed {
        logic             done;
        logic [`XLEN-1:0] data;
    } rob_view_entry_t;

    typedef rob_view_entry_t [`ROB_DEPTH-1:0] rob_view_t;

endpackage

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

`include "core_consts.svh"

    // supported rv32 subset
    // illegal marks anything else
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_MUL,
        OP_ILLEGAL
    } opcode_e;

    // decoder output, dispatch input
    typedef struct packed {
        logic                     valid;
        opcode_e                  op;
        logic [`REG_ADDR_LEN-1:0] rd;
        logic [`REG_ADDR_LEN-1:0] rs1;
        logic [`REG_ADDR_LEN-1:0] rs2;
        // operand b from imm instead of rs2
        logic                     use_imm;
        logic [`XLEN-1:0]         imm;
    } decoded_t;

endpackage

// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath and register file
`define XLEN            32
`define REG_NUM         32
`define REG_ADDR_LEN    5

// reorder buffer sizing
// tag width must cover the depth
`define ROB_DEPTH       8
`define ROB_TAG_LEN     3

// multiplier timing
// XLEN / bits per cycle gives the step count
`define MUL_BITS_PER_CYCLE  4
`define MUL_CYCLES          8

`endif
